//--- logic/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// entries in the decode queue, power of two.
`define CORE_QUEUE_DEPTH 4

// log2 of the depth.
`define CORE_QUEUE_PTR_W 2

`endif

//--- logic/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;

	typedef enum logic [3:0] {
		EQ = 4'b0000,
		NE = 4'b0001,
		CS = 4'b0010,
		CC = 4'b0011,
		MI = 4'b0100,
		PL = 4'b0101,
		VS = 4'b0110,
		VC = 4'b0111,
		HI = 4'b1000,
		LS = 4'b1001,
		GE = 4'b1010,
		LT = 4'b1011,
		GT = 4'b1100,
		LE = 4'b1101,
		AL = 4'b1110,
		NV = 4'b1111 // decoded as undefined.
	} cond_code;

	typedef enum logic [2:0] {
		DATA   = 3'd0,
		LDST   = 3'd1,
		BRANCH = 3'd2,
		MUL    = 3'd3,
		SWI    = 3'd4,
		UNDEF  = 3'd5
	} insn_class;

	typedef struct packed {
		insn_class iclass;
		cond_code  cond;
		logic      writeback;
		logic      update_flags;
		logic      link;
		logic      undefined;
		logic      execute;
		logic      swi;
	} ctrl_decode;

	typedef struct packed {
		logic [3:0] opcode;
		reg_num     rd;
		reg_num     rn;
		reg_num     rm;
		logic       is_imm;
		logic [7:0] imm8;       // zero unless is_imm.
		logic [3:0] rot4;
		logic [1:0] shift_type; // zero when is_imm.
		logic [4:0] shift_imm;
	} data_decode;

	typedef struct packed {
		logic        load;
		logic        byte_access;
		logic        up;
		logic        pre_index;
		logic        base_writeback;
		reg_num      rn;
		reg_num      rd;
		logic        off_is_imm;
		logic [11:0] off12;
	} ldst_decode;

	typedef struct packed {
		logic   accumulate;
		reg_num rd;
		reg_num rn;
		reg_num rs;
		reg_num rm;
	} mul_decode;

	typedef struct packed {
		ctrl_decode  ctrl;
		data_decode  data;
		ldst_decode  ldst;
		mul_decode   mul;
		logic [25:0] branch_offset; // byte offset, sign in bit 25.
	} insn_decode;

endpackage

//--- logic/core_decode_mux.sv
`timescale 1ns/1ps

module core_decode_mux
(
	input  core_pkg::word        insn,

	output core_pkg::ctrl_decode ctrl
);

	logic cond_nv, is_mul, is_data, is_ldst, is_branch, is_swi;
	logic reg_shift, ldst_reg_bad, is_compare;
	core_pkg::insn_class iclass;

	assign cond_nv      = insn[31:28] == core_pkg::NV;
	assign is_mul       = insn[27:22] == 6'b000000 && insn[7:4] == 4'b1001;
	assign reg_shift    = !insn[25] && insn[4]; // shift by register.
	assign ldst_reg_bad = insn[25] && insn[4];
	assign is_data      = insn[27:26] == 2'b00 && !is_mul && !reg_shift;
	assign is_ldst      = insn[27:26] == 2'b01 && !ldst_reg_bad;
	assign is_branch    = insn[27:25] == 3'b101;
	assign is_swi       = insn[27:24] == 4'b1111;
	assign is_compare   = insn[24:23] == 2'b10; // tst, teq, cmp, cmn.

	always_comb begin
		if (cond_nv)
			iclass = core_pkg::UNDEF;
		else if (is_mul)
			iclass = core_pkg::MUL;
		else if (is_data)
			iclass = core_pkg::DATA;
		else if (is_ldst)
			iclass = core_pkg::LDST;
		else if (is_branch)
			iclass = core_pkg::BRANCH;
		else if (is_swi)
			iclass = core_pkg::SWI;
		else
			iclass = core_pkg::UNDEF;
	end

	always_comb begin
		ctrl.iclass       = iclass;
		ctrl.cond         = core_pkg::cond_code'(insn[31:28]);
		ctrl.undefined    = iclass == core_pkg::UNDEF;
		ctrl.swi          = iclass == core_pkg::SWI;
		ctrl.execute      = !ctrl.undefined && !ctrl.swi;
		ctrl.link         = iclass == core_pkg::BRANCH && insn[24];
		ctrl.update_flags = (iclass == core_pkg::DATA || iclass == core_pkg::MUL) && insn[20];

		case (iclass)
			core_pkg::DATA:   ctrl.writeback = !is_compare;
			core_pkg::LDST:   ctrl.writeback = insn[20]; // loads only.
			core_pkg::BRANCH: ctrl.writeback = insn[24];
			core_pkg::MUL:    ctrl.writeback = 1'b1;
			default:          ctrl.writeback = 1'b0;
		endcase
	end

endmodule

//--- logic/core_decode_data.sv
`timescale 1ns/1ps

module core_decode_data
(
	input  core_pkg::word        insn,

	output core_pkg::data_decode data
);

	logic       is_imm;
	logic [7:0] imm8;
	logic [3:0] rot4;
	logic [1:0] shift_type;
	logic [4:0] shift_imm;

	assign is_imm = insn[25];

	// rotated immediate, bit 25 set.
	always_comb begin
		if (is_imm) begin
			imm8 = insn[7:0];
			rot4 = insn[11:8];
		end else begin
			imm8 = 8'd0;
			rot4 = 4'd0;
		end
	end

	// register shifted by immediate.
	always_comb begin
		if (!is_imm) begin
			shift_type = insn[6:5];
			shift_imm  = insn[11:7];
		end else begin
			shift_type = 2'd0;
			shift_imm  = 5'd0;
		end
	end

	always_comb begin
		data.opcode     = insn[24:21];
		data.rd         = insn[15:12];
		data.rn         = insn[19:16];
		data.rm         = insn[3:0];
		data.is_imm     = is_imm;
		data.imm8       = imm8;
		data.rot4       = rot4;
		data.shift_type = shift_type;
		data.shift_imm  = shift_imm;
	end

endmodule

//--- logic/core_decode_ldst.sv
`timescale 1ns/1ps

module core_decode_ldst
(
	input  core_pkg::word        insn,

	output core_pkg::ldst_decode ldst,
	output core_pkg::mul_decode  mul
);

	logic p_bit, u_bit, b_bit, w_bit, l_bit;

	assign p_bit = insn[24];
	assign u_bit = insn[23];
	assign b_bit = insn[22];
	assign w_bit = insn[21];
	assign l_bit = insn[20];

	always_comb begin
		ldst.load           = l_bit;
		ldst.byte_access    = b_bit;
		ldst.up             = u_bit;
		ldst.pre_index      = p_bit;
		ldst.base_writeback = w_bit || !p_bit; // post-index always writes base.
		ldst.rn             = insn[19:16];
		ldst.rd             = insn[15:12];
		ldst.off_is_imm     = !insn[25];
		ldst.off12          = insn[11:0]; // rm in 3:0 when register.
	end

	// multiply swaps rd and rn relative to data processing.
	always_comb begin
		mul.accumulate = w_bit;
		mul.rd         = insn[19:16];
		mul.rn         = insn[15:12];
		mul.rs         = insn[11:8];
		mul.rm         = insn[3:0];
	end

endmodule

//--- logic/core_decode.sv
`timescale 1ns/1ps

module core_decode
(
	input  core_pkg::word        insn,

	output core_pkg::insn_decode dec
);

	core_pkg::ctrl_decode dec_ctrl;
	core_pkg::data_decode dec_data;
	core_pkg::ldst_decode dec_ldst;
	core_pkg::mul_decode  dec_mul;
	logic [25:0]          branch_offset;

	core_decode_mux mux
	(
		.insn(insn),
		.ctrl(dec_ctrl)
	);

	core_decode_data group_data
	(
		.insn(insn),
		.data(dec_data)
	);

	core_decode_ldst group_ldst
	(
		.insn(insn),
		.ldst(dec_ldst),
		.mul(dec_mul)
	);

	// imm24 << 2, sign bit lands in bit 25.
	assign branch_offset = {insn[23:0], 2'b00};

	assign dec.ctrl          = dec_ctrl;
	assign dec.data          = dec_data;
	assign dec.ldst          = dec_ldst;
	assign dec.mul           = dec_mul;
	assign dec.branch_offset = branch_offset;

endmodule

//--- logic/core_decode_queue.sv
`include "core_cfg.svh"
`timescale 1ns/1ps

module core_decode_queue
(
	input  logic                 clk,
	input  logic                 arst_n,

	input  logic                 push,
	input  core_pkg::insn_decode wdata,
	input  logic                 pop,

	output core_pkg::insn_decode head,
	output logic                 empty,
	output logic                 full
);

	core_pkg::insn_decode mem [`CORE_QUEUE_DEPTH];

	logic [`CORE_QUEUE_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [`CORE_QUEUE_PTR_W:0]   count;
	logic                         do_push, do_pop;

	assign do_push = push && !full; // strobe while full is dropped.
	assign do_pop  = pop && !empty;

	assign empty = count == '0;
	assign full  = count == (`CORE_QUEUE_PTR_W+1)'(`CORE_QUEUE_DEPTH);
	assign head  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

//--- logic/core_cond_issue.sv
`timescale 1ns/1ps

module core_cond_issue
(
	input  logic                 clk,
	input  logic                 arst_n,

	input  logic                 issue_en,
	input  logic                 empty,
	input  core_pkg::insn_decode head,
	input  logic [3:0]           nzcv,

	output logic                 pop,
	output logic                 issue_valid,
	output core_pkg::insn_decode issue_dec,
	output logic                 cond_pass
);

	logic cond_ok, pass_next;
	logic n, z, c, v;

	assign {n, z, c, v} = nzcv;

	assign pop = issue_en && !empty && arst_n;

	always_comb begin
		case (head.ctrl.cond)
			core_pkg::EQ: cond_ok = z;
			core_pkg::NE: cond_ok = !z;
			core_pkg::CS: cond_ok = c;
			core_pkg::CC: cond_ok = !c;
			core_pkg::MI: cond_ok = n;
			core_pkg::PL: cond_ok = !n;
			core_pkg::VS: cond_ok = v;
			core_pkg::VC: cond_ok = !v;
			core_pkg::HI: cond_ok = c && !z;
			core_pkg::LS: cond_ok = !c || z;
			core_pkg::GE: cond_ok = n == v;
			core_pkg::LT: cond_ok = n != v;
			core_pkg::GT: cond_ok = !z && n == v;
			core_pkg::LE: cond_ok = z || n != v;
			core_pkg::AL: cond_ok = 1'b1;
			default:      cond_ok = 1'b0; // nv never passes.
		endcase
	end

	assign pass_next = cond_ok && !head.ctrl.undefined;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issue_valid <= 1'b0;
			cond_pass   <= 1'b0;
		end else begin
			issue_valid <= pop;
			if (pop)
				cond_pass <= pass_next;
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			issue_dec <= head; // held between issues.
	end

endmodule

//--- logic/core_frontend.sv
`timescale 1ns/1ps

module core_frontend
(
	input  logic                 clk,
	input  logic                 arst_n,

	input  core_pkg::word        insn,
	input  logic                 insn_valid,
	input  logic                 issue_en,
	input  logic [3:0]           nzcv,

	output logic                 queue_full,
	output logic                 issue_valid,
	output core_pkg::insn_decode issue_dec,
	output logic                 cond_pass
);

	core_pkg::insn_decode dec, head;
	logic                 pop, empty;

	core_decode decode
	(
		.insn(insn),
		.dec(dec)
	);

	core_decode_queue queue
	(
		.clk(clk),
		.arst_n(arst_n),
		.push(insn_valid),
		.wdata(dec),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full(queue_full)
	);

	core_cond_issue issue
	(
		.clk(clk),
		.arst_n(arst_n),
		.issue_en(issue_en),
		.empty(empty),
		.head(head),
		.nzcv(nzcv),
		.pop(pop),
		.issue_valid(issue_valid),
		.issue_dec(issue_dec),
		.cond_pass(cond_pass)
	);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period.
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1; // released away from the active edge.
	end

endmodule

//--- tests/core_frontend_tb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_frontend_tb;

	localparam int num_insns = 300 + 16 * 8 * 2 + `CORE_QUEUE_DEPTH + 400;

	typedef struct packed {
		core_pkg::insn_decode dec;
		logic                 pass;
	} expect_t;

	logic                 clk, arst_n;
	core_pkg::word        insn;
	logic                 insn_valid, issue_en, queue_full, issue_valid, cond_pass;
	logic [3:0]           nzcv;
	core_pkg::insn_decode issue_dec;

	expect_t exp_q[$];
	expect_t got_exp;
	string   test_name;
	int      errors, issued, sent, guard, base_issued;
	logic    full_seen;

	tb_clock clock_gen (.clk(clk), .arst_n(arst_n));

	core_frontend dut_i
	(
		.clk(clk),
		.arst_n(arst_n),
		.insn(insn),
		.insn_valid(insn_valid),
		.issue_en(issue_en),
		.nzcv(nzcv),
		.queue_full(queue_full),
		.issue_valid(issue_valid),
		.issue_dec(issue_dec),
		.cond_pass(cond_pass)
	);

	// reference decode built from the instruction set rules.
	function automatic core_pkg::insn_decode model_decode(input logic [31:0] w);
		core_pkg::insn_decode d;
		core_pkg::insn_class  cls;
		int                   off;
		d = '0;
		if (w[31:28] == 4'hf)
			cls = core_pkg::UNDEF;
		else if (w[27:22] == 6'd0 && w[7:4] == 4'b1001)
			cls = core_pkg::MUL;
		else if (w[27:26] == 2'b00)
			cls = (w[25] || !w[4]) ? core_pkg::DATA : core_pkg::UNDEF;
		else if (w[27:26] == 2'b01)
			cls = (w[25] && w[4]) ? core_pkg::UNDEF : core_pkg::LDST;
		else if (w[27:25] == 3'b101)
			cls = core_pkg::BRANCH;
		else if (w[27:24] == 4'hf)
			cls = core_pkg::SWI;
		else
			cls = core_pkg::UNDEF;
		d.ctrl.iclass       = cls;
		d.ctrl.cond         = core_pkg::cond_code'(w[31:28]);
		d.ctrl.undefined    = cls == core_pkg::UNDEF;
		d.ctrl.swi          = cls == core_pkg::SWI;
		d.ctrl.execute      = !(cls == core_pkg::UNDEF || cls == core_pkg::SWI);
		d.ctrl.link         = cls == core_pkg::BRANCH && w[24];
		d.ctrl.update_flags = w[20] && (cls == core_pkg::DATA || cls == core_pkg::MUL);
		if (cls == core_pkg::DATA)
			d.ctrl.writeback = w[24:21] < 4'd8 || w[24:21] > 4'd11; // compares write nothing.
		else if (cls == core_pkg::LDST)
			d.ctrl.writeback = w[20];
		else if (cls == core_pkg::BRANCH)
			d.ctrl.writeback = w[24];
		else
			d.ctrl.writeback = cls == core_pkg::MUL;
		d.data.opcode = w[24:21];
		d.data.rd     = w[15:12];
		d.data.rn     = w[19:16];
		d.data.rm     = w[3:0];
		d.data.is_imm = w[25];
		if (w[25]) begin
			d.data.imm8 = w[7:0];
			d.data.rot4 = w[11:8];
		end else begin
			d.data.shift_type = w[6:5];
			d.data.shift_imm  = w[11:7];
		end
		d.ldst          = {w[20], w[22], w[23], w[24], w[21] | ~w[24], w[19:16], w[15:12],
			~w[25], w[11:0]};
		d.mul           = {w[21], w[19:16], w[15:12], w[11:8], w[3:0]};
		off             = int'($signed(w[23:0])) * 4; // word count to signed bytes.
		d.branch_offset = off[25:0];
		return d;
	endfunction

	// pairs of codes share a test, odd codes invert it.
	function automatic logic cond_model(input logic [3:0] cond, input logic [3:0] f,
		input logic undef);
		logic base;
		case (cond[3:1])
			3'd0: base = f[2];
			3'd1: base = f[1];
			3'd2: base = f[3];
			3'd3: base = f[0];
			3'd4: base = f[1] && !f[2];
			3'd5: base = f[3] == f[0];
			3'd6: base = !f[2] && f[3] == f[0];
			default: base = 1'b1;
		endcase
		return (base ^ cond[0]) && !undef;
	endfunction

	function automatic logic [31:0] make_word(input int kind, input logic [3:0] cond);
		logic [31:0] r;
		r = $urandom;
		case (kind)
			0: return {cond, 3'b001, r[24:0]};                    // data, immediate.
			1: return {cond, 3'b000, r[24:5], 1'b0, r[3:0]};      // data, shift by imm.
			2: return {cond, 2'b01, r[25:5], r[25] ? 1'b0 : r[4], r[3:0]};
			3: return {cond, 3'b101, r[24:0]};
			4: return {cond, 6'b000000, r[21:8], 4'b1001, r[3:0]};
			5: return {cond, 4'b1111, r[23:0]};
			default: return {cond, r[27:0]};
		endcase
	endfunction

	task automatic check_field(input string field, input logic [127:0] exp_v,
		input logic [127:0] act_v);
		if (exp_v !== act_v) begin
			$display("Fail %s %s: expected %0h, actual %0h", test_name, field, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic drive_word(input logic [31:0] w);
		expect_t e;
		e.dec  = model_decode(w);
		e.pass = cond_model(w[31:28], nzcv, e.dec.ctrl.undefined);
		insn       = w;
		insn_valid = 1'b1;
		exp_q.push_back(e);
	endtask

	task automatic send_word(input logic [31:0] w);
		@(negedge clk);
		while (queue_full) begin
			insn_valid = 1'b0;
			@(negedge clk);
		end
		drive_word(w);
	endtask

	task automatic drain_queue(input int limit);
		int waited;
		waited = 0;
		@(negedge clk);
		insn_valid = 1'b0;
		issue_en   = 1'b1;
		while (exp_q.size() != 0 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("%s: %0d records never issued", test_name, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	// outputs settle after the rising edge, so look at them half a cycle later.
	always @(negedge clk) begin
		if (issue_valid) begin
			if (exp_q.size() == 0) begin
				$display("%s: a record issued with no expected record left", test_name);
				errors++;
			end else begin
				got_exp = exp_q.pop_front();
				issued++;
				check_field("ctrl", 128'(got_exp.dec.ctrl), 128'(issue_dec.ctrl));
				check_field("data", 128'(got_exp.dec.data), 128'(issue_dec.data));
				check_field("ldst", 128'(got_exp.dec.ldst), 128'(issue_dec.ldst));
				check_field("mul", 128'(got_exp.dec.mul), 128'(issue_dec.mul));
				check_field("branch_offset", 128'(got_exp.dec.branch_offset),
					128'(issue_dec.branch_offset));
				check_field("cond_pass", 128'(got_exp.pass), 128'(cond_pass));
			end
		end
	end

	initial begin
		repeat (num_insns * 40 + 2000) @(posedge clk);
		$display("watchdog expired with %0d errors so far", errors);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(81));
		insn       = '0;
		insn_valid = 1'b0;
		issue_en   = 1'b0;
		nzcv       = 4'h0;
		errors     = 0;
		issued     = 0;

		test_name = "reset";
		repeat (14) begin
			@(negedge clk);
			check_field("issue_valid", 128'(1'b0), 128'(issue_valid));
			check_field("queue_full", 128'(1'b0), 128'(queue_full));
		end

		test_name = "class_decode";
		issue_en  = 1'b1;
		nzcv      = 4'($urandom);
		repeat (300)
			send_word(make_word($urandom % 7, 4'($urandom)));
		drain_queue(100);

		test_name = "conditions";
		for (int c = 0; c < 16; c++) begin
			for (int k = 0; k < 8; k++) begin
				drain_queue(50);
				nzcv = 4'($urandom); // model queue is empty here.
				send_word(make_word($urandom % 6, 4'(c)));
				send_word(make_word($urandom % 6, 4'(c)));
			end
		end
		drain_queue(50);

		test_name = "backpressure";
		issue_en  = 1'b0;
		sent      = 0;
		guard     = 0;
		full_seen = 1'b0;
		while (!full_seen && guard < 4 * `CORE_QUEUE_DEPTH) begin
			@(negedge clk);
			guard++;
			if (issue_valid) begin
				$display("%s: record issued while issue_en was low", test_name);
				errors++;
			end
			if (queue_full) begin
				insn_valid = 1'b0;
				full_seen  = 1'b1;
			end else begin
				drive_word(make_word($urandom % 6, 4'($urandom)));
				sent++;
			end
		end
		if (!full_seen) begin
			$display("%s: queue_full never rose", test_name);
			errors++;
		end
		check_field("strobes_to_full", 128'(`CORE_QUEUE_DEPTH), 128'(sent));
		base_issued = issued;
		drain_queue(50);
		check_field("issued_after_full", 128'(`CORE_QUEUE_DEPTH),
			128'(issued - base_issued));

		test_name   = "random_throttle";
		sent        = 0;
		base_issued = issued;
		while (sent < 400) begin
			@(negedge clk);
			issue_en = 1'($urandom);
			if (exp_q.size() == 0 && $urandom % 4 == 0)
				nzcv = 4'($urandom);
			if (!queue_full && $urandom % 2 == 1) begin
				drive_word(make_word($urandom % 7, 4'($urandom)));
				sent++;
			end else begin
				insn_valid = 1'b0;
			end
		end
		drain_queue(100);
		check_field("issued_count", 128'(sent), 128'(issued - base_issued));

		$display("errors: %0d, records issued: %0d", errors, issued);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- src.f
+incdir+logic
logic/core_pkg.sv
logic/core_decode_mux.sv
logic/core_decode_data.sv
logic/core_decode_ldst.sv
logic/core_decode.sv
logic/core_decode_queue.sv
logic/core_cond_issue.sv
logic/core_frontend.sv
tests/tb_clock.sv
tests/core_frontend_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core_frontend testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module core_frontend_tb -f src.f -o sim_core_frontend

./obj_dir/sim_core_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
	exit 0
fi
exit 1
